/* csr_file.f */
src/csr_pkg.sv
src/csr_access_check.sv
src/trap_csr_bank.sv
src/hpm_counters.sv
src/csr_read_mux.sv
src/csr_file_top.sv
dv/csr_file_tb.sv

/* dv/csr_file_tb.sv */
// Testbench for the machine-mode CSR file
// Directed tests for reset, write forms, faults, counters, user gating, traps
module csr_file_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // Tests take roughly 200 cycles after reset
  localparam int unsigned TIMEOUT_CYCLES = 2000;

  logic                  CLK;
  logic                  nRST;
  csr_pkg::csr_req_t     csr_req;
  csr_pkg::priv_level_t  priv;
  logic                  inst_ret;
  logic [63:0]           mtime;
  csr_pkg::trap_inject_t trap_inject;
  csr_pkg::csr_word_t    rdata;
  logic                  invalid_csr;
  csr_pkg::trap_state_t  trap_state;

  int          seed = 32'ha691;
  int unsigned cycle_count = 0;

  csr_file_top dut0 (
    .CLK         (CLK),
    .nRST        (nRST),
    .csr_req     (csr_req),
    .priv        (priv),
    .inst_ret    (inst_ret),
    .mtime       (mtime),
    .trap_inject (trap_inject),
    .rdata       (rdata),
    .invalid_csr (invalid_csr),
    .trap_state  (trap_state)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $fatal(1, "Simulation timed out");
    end
  end

  task automatic check_word(input string name, input csr_pkg::csr_word_t expected,
                            input csr_pkg::csr_word_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
      $display("Regression failed");
      $fatal(1, "Wrong CSR value in %s", name);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected invalid_csr %b, actual %b", name, expected, actual);
      $display("Regression failed");
      $fatal(1, "Wrong invalid_csr in %s", name);
    end
  endtask

  function automatic csr_pkg::csr_req_t make_req(input csr_pkg::csr_addr_t addr,
      input logic wr, input logic st, input logic clr, input logic ro, input logic vw,
      input csr_pkg::csr_word_t operand);
    csr_pkg::csr_req_t req;
    req             = '0;
    req.addr        = addr;
    req.write       = wr;
    req.set         = st;
    req.clear       = clr;
    req.read_only   = ro;
    req.valid_write = vw;
    req.operand     = operand;
    return req;
  endfunction

  // Drive on the rising edge and sample at the falling edge
  task automatic drive_req(input csr_pkg::csr_req_t req);
    @(posedge CLK);
    csr_req <= req;
    @(negedge CLK);
  endtask

  task automatic read_csr(input csr_pkg::csr_addr_t addr, output csr_pkg::csr_word_t value);
    drive_req(make_req(addr, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, '0));
    value = rdata;
  endtask

  task automatic write_op(input csr_pkg::csr_addr_t addr, input logic wr, input logic st,
                          input logic clr, input csr_pkg::csr_word_t operand);
    drive_req(make_req(addr, wr, st, clr, 1'b0, 1'b1, operand));
  endtask

  task automatic expect_read(input string name, input csr_pkg::csr_addr_t addr,
                             input csr_pkg::csr_word_t expected);
    csr_pkg::csr_word_t value;
    read_csr(addr, value);
    check_word(name, expected, value);
  endtask

  // Idle request lets a pending write land once
  task automatic set_priv(input csr_pkg::priv_level_t level);
    @(posedge CLK);
    priv    <= level;
    csr_req <= '0;
  endtask

  task automatic test_reset_values();
    expect_read("reset_values", csr_pkg::MSTATUS_ADDR, 32'h0020_0000);
    expect_read("reset_values", csr_pkg::MCOUNTEREN_ADDR, 32'hFFFF_FFFF);
    expect_read("reset_values", csr_pkg::MHARTID_ADDR, csr_pkg::HART_ID);
    expect_read("reset_values", csr_pkg::MISA_ADDR, 32'h4010_0100);
    expect_read("reset_values", csr_pkg::MVENDORID_ADDR, 32'h0);
    expect_read("reset_values", csr_pkg::MEPC_ADDR, 32'h0);
    expect_read("reset_values", csr_pkg::MTVEC_ADDR, 32'h0);
  endtask

  task automatic test_write_forms();
    csr_pkg::csr_word_t op1, op2, op3;
    op1 = $random(seed);
    op2 = $random(seed);
    op3 = $random(seed);
    write_op(csr_pkg::MSCRATCH_ADDR, 1'b1, 1'b0, 1'b0, op1);
    expect_read("write_forms", csr_pkg::MSCRATCH_ADDR, op1);
    write_op(csr_pkg::MSCRATCH_ADDR, 1'b0, 1'b1, 1'b0, op2);
    expect_read("write_forms", csr_pkg::MSCRATCH_ADDR, op1 | op2);
    write_op(csr_pkg::MSCRATCH_ADDR, 1'b0, 1'b0, 1'b1, op3);
    expect_read("write_forms", csr_pkg::MSCRATCH_ADDR, ~op3 & (op1 | op2));
    // tw, mpie, mie with mpp=S, which falls back to U
    write_op(csr_pkg::MSTATUS_ADDR, 1'b1, 1'b0, 1'b0, 32'h0020_0888);
    expect_read("write_forms", csr_pkg::MSTATUS_ADDR, 32'h0020_0088);
    write_op(csr_pkg::MTVEC_ADDR, 1'b1, 1'b0, 1'b0, 32'h8000_1003);
    expect_read("write_forms", csr_pkg::MTVEC_ADDR, 32'h8000_1000);
    write_op(csr_pkg::MIE_ADDR, 1'b1, 1'b0, 1'b0, 32'hFFFF_FFFF);
    expect_read("write_forms", csr_pkg::MIE_ADDR, 32'h0000_0888);
  endtask

  task automatic test_faults();
    write_op(csr_pkg::MSCRATCH_ADDR, 1'b1, 1'b0, 1'b0, 32'h1234_5678);
    set_priv(csr_pkg::U_MODE);
    write_op(csr_pkg::MSCRATCH_ADDR, 1'b1, 1'b0, 1'b0, 32'hDEAD_BEEF);
    check_flag("faults", 1'b1, invalid_csr);  // M-level CSR from U
    set_priv(csr_pkg::M_MODE);
    expect_read("faults", csr_pkg::MSCRATCH_ADDR, 32'h1234_5678);
    write_op(csr_pkg::MHARTID_ADDR, 1'b1, 1'b0, 1'b0, 32'hFFFF_FFFF);
    check_flag("faults", 1'b1, invalid_csr);
    expect_read("faults", csr_pkg::MHARTID_ADDR, csr_pkg::HART_ID);
    write_op(12'h7C0, 1'b1, 1'b0, 1'b0, 32'h0000_0001);
    check_flag("faults", 1'b1, invalid_csr);  // Unlisted address
    // csrrs with x0 source on a read-only CSR
    drive_req(make_req(csr_pkg::MHARTID_ADDR, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, '0));
    check_flag("faults", 1'b0, invalid_csr);
    check_word("faults", csr_pkg::HART_ID, rdata);
  endtask

  task automatic test_counters();
    csr_pkg::csr_word_t v, hi;
    int unsigned k, n, i;
    v  = $random(seed);
    hi = $random(seed);
    k  = 3 + ({$random(seed)} % 8);
    n  = 2 + ({$random(seed)} % 6);
    write_op(csr_pkg::MCYCLE_ADDR, 1'b1, 1'b0, 1'b0, v);
    expect_read("counters", csr_pkg::MCYCLE_ADDR, v);
    repeat (k) @(posedge CLK);
    @(negedge CLK);
    check_word("counters", v + k, rdata);
    write_op(csr_pkg::MCOUNTINHIBIT_ADDR, 1'b0, 1'b1, 1'b0, 32'h1);
    // Two more counts before the inhibit lands
    expect_read("counters", csr_pkg::MCYCLE_ADDR, v + k + 2);
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    check_word("counters", v + k + 2, rdata);  // cycle held by inhibit
    expect_read("counters", csr_pkg::MINSTRET_ADDR, 32'h0);  // Nothing retired yet
    for (i = 0; i < n; i++) begin
      @(posedge CLK);
      inst_ret <= 1'b1;
      @(posedge CLK);
      inst_ret <= 1'b0;
    end
    @(negedge CLK);
    check_word("counters", n, rdata);
    write_op(csr_pkg::MCYCLEH_ADDR, 1'b1, 1'b0, 1'b0, hi);
    expect_read("counters", csr_pkg::MCYCLEH_ADDR, hi);
    write_op(csr_pkg::MCOUNTINHIBIT_ADDR, 1'b0, 1'b0, 1'b1, 32'h1);
    expect_read("counters", csr_pkg::MCOUNTINHIBIT_ADDR, 32'h0);
  endtask

  task automatic test_user_gating();
    logic [63:0] t;
    t = {$random(seed), $random(seed)};
    @(posedge CLK);
    mtime <= t;
    set_priv(csr_pkg::U_MODE);
    expect_read("user_gating", csr_pkg::TIME_ADDR, t[31:0]);
    check_flag("user_gating", 1'b0, invalid_csr);
    expect_read("user_gating", csr_pkg::TIMEH_ADDR, t[63:32]);
    set_priv(csr_pkg::M_MODE);
    write_op(csr_pkg::MCOUNTEREN_ADDR, 1'b0, 1'b0, 1'b1, 32'h1);
    set_priv(csr_pkg::U_MODE);
    drive_req(make_req(csr_pkg::CYCLE_ADDR, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, '0));
    check_flag("user_gating", 1'b1, invalid_csr);
    drive_req(make_req(csr_pkg::INSTRET_ADDR, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, '0));
    check_flag("user_gating", 1'b0, invalid_csr);  // ir still enabled
    set_priv(csr_pkg::M_MODE);
  endtask

  task automatic test_trap_injection();
    csr_pkg::trap_inject_t inj;
    inj           = '0;
    inj.mepc_en   = 1'b1;
    inj.mepc      = 32'h0000_2468;
    inj.mcause_en = 1'b1;
    inj.mcause    = 32'h8000_0007;
    inj.mtval_en  = 1'b1;
    inj.mtval     = 32'h0000_0BAD;
    inj.mstatus_en = 1'b1;
    inj.mstatus   = csr_pkg::mstatus_t'(32'h0000_1880);  // mpp=M, mpie
    @(posedge CLK);
    trap_inject <= inj;
    csr_req     <= make_req(csr_pkg::MEPC_ADDR, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 32'h0000_1357);
    @(posedge CLK);
    trap_inject <= '0;
    csr_req     <= make_req(csr_pkg::MEPC_ADDR, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, '0);
    @(negedge CLK);
    check_word("trap_injection", 32'h0000_2468, trap_state.mepc);
    check_word("trap_injection", 32'h8000_0007, trap_state.mcause);
    check_word("trap_injection", 32'h0000_0BAD, trap_state.mtval);
    check_word("trap_injection", 32'h0000_1880, trap_state.mstatus);
    check_word("trap_injection", 32'h0000_2468, rdata);
    expect_read("trap_injection", csr_pkg::MCAUSE_ADDR, 32'h8000_0007);
    expect_read("trap_injection", csr_pkg::MTVAL_ADDR, 32'h0000_0BAD);
    expect_read("trap_injection", csr_pkg::MSTATUS_ADDR, 32'h0000_1880);
    inj        = '0;
    inj.mip_en = 1'b1;
    inj.mip    = csr_pkg::irq_bits_t'(32'h0000_0088);  // msi and mti pending
    @(posedge CLK);
    trap_inject <= inj;
    @(posedge CLK);
    trap_inject <= '0;
    @(negedge CLK);
    check_word("trap_injection", 32'h0000_0088, trap_state.mip);
    expect_read("trap_injection", csr_pkg::MIP_ADDR, 32'h0000_0088);
  endtask

  initial begin
    nRST        = 1'b0;
    csr_req     = '0;
    priv        = csr_pkg::M_MODE;
    inst_ret    = 1'b0;
    mtime       = '0;
    trap_inject = '0;
    repeat (16) @(posedge CLK);
    nRST <= 1'b1;
    test_reset_values();
    test_write_forms();
    test_faults();
    test_counters();
    test_user_gating();
    test_trap_injection();
    $display("Regression passed");
    $finish;
  end

endmodule

/* run.sh */
#!/bin/sh
# Build the CSR file testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module csr_file_tb -f csr_file.f

./obj_dir/Vcsr_file_tb | tee sim.log

if grep -q "Regression passed" sim.log; then
  echo "Simulation PASS"
else
  echo "Simulation FAIL"
  exit 1
fi

/* src/csr_access_check.sv */
// CSR access check
// Write value forms, privilege and read-only checks, write enable decode
module csr_access_check (
  input  csr_pkg::csr_req_t    csr_req,
  input  csr_pkg::priv_level_t priv,
  input  csr_pkg::csr_word_t   rdata,
  output csr_pkg::csr_word_t   wdata,
  output csr_pkg::csr_wsel_t   wsel,
  output logic                 priv_fault
);

  logic csr_op;
  logic ro_violation;
  logic level_violation;

  assign csr_op = csr_req.write | csr_req.set | csr_req.clear;

  // Write, set and clear forms against the current value
  always_comb begin
    if (csr_req.write) begin
      wdata = csr_req.operand;
    end else if (csr_req.set) begin
      wdata = csr_req.operand | rdata;
    end else if (csr_req.clear) begin
      wdata = ~csr_req.operand & rdata;
    end else begin
      wdata = csr_req.operand;
    end
  end

  assign ro_violation    = (csr_req.addr[11:10] == 2'b11) && !csr_req.read_only;
  assign level_violation = csr_req.addr[9:8] > priv;  // Not enough privilege
  assign priv_fault      = csr_op & (ro_violation | level_violation);

  // One-hot enables, only for legal writes
  always_comb begin
    wsel = '0;
    if (csr_req.valid_write && !priv_fault) begin
      case (csr_req.addr)
        csr_pkg::MSTATUS_ADDR:       wsel.mstatus       = 1'b1;
        csr_pkg::MTVEC_ADDR:         wsel.mtvec         = 1'b1;
        csr_pkg::MIE_ADDR:           wsel.mie           = 1'b1;
        csr_pkg::MIP_ADDR:           wsel.mip           = 1'b1;
        csr_pkg::MSCRATCH_ADDR:      wsel.mscratch      = 1'b1;
        csr_pkg::MEPC_ADDR:          wsel.mepc          = 1'b1;
        csr_pkg::MCAUSE_ADDR:        wsel.mcause        = 1'b1;
        csr_pkg::MTVAL_ADDR:         wsel.mtval         = 1'b1;
        csr_pkg::MCOUNTEREN_ADDR:    wsel.mcounteren    = 1'b1;
        csr_pkg::MCOUNTINHIBIT_ADDR: wsel.mcountinhibit = 1'b1;
        csr_pkg::MCYCLE_ADDR:        wsel.mcycle        = 1'b1;
        csr_pkg::MCYCLEH_ADDR:       wsel.mcycleh       = 1'b1;
        csr_pkg::MINSTRET_ADDR:      wsel.minstret      = 1'b1;
        csr_pkg::MINSTRETH_ADDR:     wsel.minstreth     = 1'b1;
        default:                     wsel               = '0;
      endcase
    end
  end

endmodule

/* src/csr_file_top.sv */
// Machine-mode CSR file top level
// Access check, trap register bank, counters and read mux
module csr_file_top (
  input  logic                  CLK,
  input  logic                  nRST,
  input  csr_pkg::csr_req_t     csr_req,
  input  csr_pkg::priv_level_t  priv,
  input  logic                  inst_ret,
  input  logic [63:0]           mtime,
  input  csr_pkg::trap_inject_t trap_inject,
  output csr_pkg::csr_word_t    rdata,
  output logic                  invalid_csr,
  output csr_pkg::trap_state_t  trap_state
);

  csr_pkg::csr_word_t      wdata;
  csr_pkg::csr_wsel_t      wsel;
  csr_pkg::counter_state_t counter_state;
  logic                    csr_op;
  logic                    priv_fault;
  logic                    addr_fault;

  assign csr_op      = csr_req.write | csr_req.set | csr_req.clear;
  assign invalid_csr = priv_fault | addr_fault;

  csr_access_check access_check0 (
    .csr_req    (csr_req),
    .priv       (priv),
    .rdata      (rdata),
    .wdata      (wdata),
    .wsel       (wsel),
    .priv_fault (priv_fault)
  );

  trap_csr_bank trap_bank0 (
    .CLK         (CLK),
    .nRST        (nRST),
    .wdata       (wdata),
    .wsel        (wsel),
    .trap_inject (trap_inject),
    .trap_state  (trap_state)
  );

  hpm_counters counters0 (
    .CLK           (CLK),
    .nRST          (nRST),
    .wdata         (wdata),
    .wsel          (wsel),
    .inhibit       (trap_state.mcountinhibit),
    .inst_ret      (inst_ret),
    .counter_state (counter_state)
  );

  csr_read_mux read_mux0 (
    .addr          (csr_req.addr),
    .csr_op        (csr_op),
    .priv          (priv),
    .trap_state    (trap_state),
    .counter_state (counter_state),
    .mtime         (mtime),
    .rdata         (rdata),
    .addr_fault    (addr_fault)
  );

endmodule

/* src/csr_pkg.sv */
// Machine-mode CSR package
// Addresses, privilege levels, register layouts and port structs
package csr_pkg;

  typedef logic [31:0] csr_word_t;
  typedef logic [11:0] csr_addr_t;

  typedef enum logic [1:0] {
    U_MODE        = 2'd0,
    S_MODE        = 2'd1,
    RESERVED_MODE = 2'd2,
    M_MODE        = 2'd3
  } priv_level_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'd0,
    VECTORED = 2'd1
  } mtvec_mode_t;

  // Machine trap setup and handling
  localparam csr_addr_t MSTATUS_ADDR       = 12'h300;
  localparam csr_addr_t MISA_ADDR          = 12'h301;
  localparam csr_addr_t MIE_ADDR           = 12'h304;
  localparam csr_addr_t MTVEC_ADDR         = 12'h305;
  localparam csr_addr_t MCOUNTEREN_ADDR    = 12'h306;
  localparam csr_addr_t MSTATUSH_ADDR      = 12'h310;
  localparam csr_addr_t MCOUNTINHIBIT_ADDR = 12'h320;
  localparam csr_addr_t MSCRATCH_ADDR      = 12'h340;
  localparam csr_addr_t MEPC_ADDR          = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR        = 12'h342;
  localparam csr_addr_t MTVAL_ADDR         = 12'h343;
  localparam csr_addr_t MIP_ADDR           = 12'h344;
  // Counters, machine and user views
  localparam csr_addr_t MCYCLE_ADDR        = 12'hB00;
  localparam csr_addr_t MINSTRET_ADDR      = 12'hB02;
  localparam csr_addr_t MCYCLEH_ADDR       = 12'hB80;
  localparam csr_addr_t MINSTRETH_ADDR     = 12'hB82;
  localparam csr_addr_t CYCLE_ADDR         = 12'hC00;
  localparam csr_addr_t TIME_ADDR          = 12'hC01;
  localparam csr_addr_t INSTRET_ADDR       = 12'hC02;
  localparam csr_addr_t CYCLEH_ADDR        = 12'hC80;
  localparam csr_addr_t TIMEH_ADDR         = 12'hC81;
  localparam csr_addr_t INSTRETH_ADDR      = 12'hC82;
  // Machine information
  localparam csr_addr_t MVENDORID_ADDR     = 12'hF11;
  localparam csr_addr_t MARCHID_ADDR       = 12'hF12;
  localparam csr_addr_t MIMPID_ADDR        = 12'hF13;
  localparam csr_addr_t MHARTID_ADDR       = 12'hF14;
  localparam csr_addr_t MCONFIGPTR_ADDR    = 12'hF15;

  localparam csr_word_t HART_ID       = 32'h0000_0000;
  localparam csr_word_t MISA_VALUE    = 32'h4010_0100;  // RV32, I and U
  localparam csr_word_t MSTATUS_WMASK = 32'h0022_1888;  // mie, mpie, mpp, mprv, tw
  localparam csr_word_t IRQ_MASK      = 32'h0000_0888;  // msi, mti, mei

  typedef struct packed {
    logic [9:0]  reserved_31_22;  // sd and S-mode bits read zero
    logic        tw;
    logic [2:0]  reserved_20_18;
    logic        mprv;
    logic [3:0]  reserved_16_13;  // xs, fs
    priv_level_t mpp;
    logic [2:0]  reserved_10_8;   // vs, spp
    logic        mpie;
    logic [2:0]  reserved_6_4;
    logic        mie;
    logic [2:0]  reserved_2_0;
  } mstatus_t;

  typedef struct packed {
    logic [29:0] base;
    mtvec_mode_t mode;
  } mtvec_t;

  // Shared by mie and mip
  typedef struct packed {
    logic [19:0] reserved_31_12;
    logic        mei;
    logic [2:0]  reserved_10_8;
    logic        mti;
    logic [2:0]  reserved_6_4;
    logic        msi;
    logic [2:0]  reserved_2_0;
  } irq_bits_t;

  // Shared by mcounteren and mcountinhibit
  typedef struct packed {
    logic [28:0] reserved_31_3;
    logic        ir;
    logic        tm;
    logic        cy;
  } counter_en_t;

  typedef struct packed {
    csr_addr_t addr;
    logic      write;
    logic      set;
    logic      clear;
    logic      read_only;
    logic      valid_write;
    csr_word_t operand;
  } csr_req_t;

  typedef struct packed {
    logic mstatus;
    logic mtvec;
    logic mie;
    logic mip;
    logic mscratch;
    logic mepc;
    logic mcause;
    logic mtval;
    logic mcounteren;
    logic mcountinhibit;
    logic mcycle;
    logic mcycleh;
    logic minstret;
    logic minstreth;
  } csr_wsel_t;

  typedef struct packed {
    logic      mstatus_en;
    mstatus_t  mstatus;
    logic      mepc_en;
    csr_word_t mepc;
    logic      mcause_en;
    csr_word_t mcause;
    logic      mtval_en;
    csr_word_t mtval;
    logic      mip_en;
    irq_bits_t mip;
  } trap_inject_t;

  typedef struct packed {
    mstatus_t    mstatus;
    mtvec_t      mtvec;
    irq_bits_t   mie;
    irq_bits_t   mip;
    csr_word_t   mepc;
    csr_word_t   mcause;
    csr_word_t   mtval;
    csr_word_t   mscratch;
    counter_en_t mcounteren;
    counter_en_t mcountinhibit;
  } trap_state_t;

  typedef struct packed {
    logic [63:0] cycle;
    logic [63:0] instret;
  } counter_state_t;

endpackage

/* src/csr_read_mux.sv */
// CSR read data multiplexer
// User counter gating by mcounteren, unknown address detection
module csr_read_mux (
  input  csr_pkg::csr_addr_t      addr,
  input  logic                    csr_op,
  input  csr_pkg::priv_level_t    priv,
  input  csr_pkg::trap_state_t    trap_state,
  input  csr_pkg::counter_state_t counter_state,
  input  logic [63:0]             mtime,
  output csr_pkg::csr_word_t      rdata,
  output logic                    addr_fault
);

  logic user_mode;
  logic high_half;

  assign user_mode = (priv == csr_pkg::U_MODE);
  assign high_half = addr[7];  // 0xC8x and 0xB8x select bits 63:32

  always_comb begin
    rdata      = '0;
    addr_fault = 1'b0;
    case (addr)
      // Fixed information registers
      csr_pkg::MVENDORID_ADDR,
      csr_pkg::MARCHID_ADDR,
      csr_pkg::MIMPID_ADDR,
      csr_pkg::MCONFIGPTR_ADDR,
      csr_pkg::MSTATUSH_ADDR:      rdata = '0;
      csr_pkg::MHARTID_ADDR:       rdata = csr_pkg::HART_ID;
      csr_pkg::MISA_ADDR:          rdata = csr_pkg::MISA_VALUE;
      // Trap registers
      csr_pkg::MSTATUS_ADDR:       rdata = trap_state.mstatus;
      csr_pkg::MTVEC_ADDR:         rdata = trap_state.mtvec;
      csr_pkg::MIE_ADDR:           rdata = trap_state.mie;
      csr_pkg::MIP_ADDR:           rdata = trap_state.mip;
      csr_pkg::MSCRATCH_ADDR:      rdata = trap_state.mscratch;
      csr_pkg::MEPC_ADDR:          rdata = trap_state.mepc;
      csr_pkg::MCAUSE_ADDR:        rdata = trap_state.mcause;
      csr_pkg::MTVAL_ADDR:         rdata = trap_state.mtval;
      csr_pkg::MCOUNTEREN_ADDR:    rdata = trap_state.mcounteren;
      csr_pkg::MCOUNTINHIBIT_ADDR: rdata = trap_state.mcountinhibit;
      // Machine counter views
      csr_pkg::MCYCLE_ADDR,
      csr_pkg::MCYCLEH_ADDR: begin
        rdata = high_half ? counter_state.cycle[63:32] : counter_state.cycle[31:0];
      end
      csr_pkg::MINSTRET_ADDR,
      csr_pkg::MINSTRETH_ADDR: begin
        rdata = high_half ? counter_state.instret[63:32] : counter_state.instret[31:0];
      end
      // User aliases, gated in U mode
      csr_pkg::CYCLE_ADDR,
      csr_pkg::CYCLEH_ADDR: begin
        if (user_mode && !trap_state.mcounteren.cy) begin
          addr_fault = 1'b1;
        end else begin
          rdata = high_half ? counter_state.cycle[63:32] : counter_state.cycle[31:0];
        end
      end
      csr_pkg::TIME_ADDR,
      csr_pkg::TIMEH_ADDR: begin
        if (user_mode && !trap_state.mcounteren.tm) begin
          addr_fault = 1'b1;
        end else begin
          rdata = high_half ? mtime[63:32] : mtime[31:0];
        end
      end
      csr_pkg::INSTRET_ADDR,
      csr_pkg::INSTRETH_ADDR: begin
        if (user_mode && !trap_state.mcounteren.ir) begin
          addr_fault = 1'b1;
        end else begin
          rdata = high_half ? counter_state.instret[63:32] : counter_state.instret[31:0];
        end
      end
      default: addr_fault = csr_op;  // No such CSR
    endcase
  end

endmodule

/* src/hpm_counters.sv */
// 64-bit cycle and instret counters
// Increment with inhibit, software writes per 32-bit half
module hpm_counters (
  input  logic                    CLK,
  input  logic                    nRST,
  input  csr_pkg::csr_word_t      wdata,
  input  csr_pkg::csr_wsel_t      wsel,
  input  csr_pkg::counter_en_t    inhibit,
  input  logic                    inst_ret,
  output csr_pkg::counter_state_t counter_state
);

  csr_pkg::counter_state_t counter_d;

  // A written half replaces the increment for that cycle
  function automatic logic [63:0] next_count(
    input logic [63:0]        count,
    input logic               step,
    input logic               lo_we,
    input logic               hi_we,
    input csr_pkg::csr_word_t value
  );
    logic [63:0] result;
    result = count + 64'(step);
    if (lo_we) begin
      result = {count[63:32], value};
    end
    if (hi_we) begin
      result = {value, count[31:0]};
    end
    return result;
  endfunction

  always_comb begin
    counter_d.cycle   = next_count(counter_state.cycle, ~inhibit.cy,
                                   wsel.mcycle, wsel.mcycleh, wdata);
    counter_d.instret = next_count(counter_state.instret, ~inhibit.ir & inst_ret,
                                   wsel.minstret, wsel.minstreth, wdata);
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      counter_state <= '0;
    end else begin
      counter_state <= counter_d;
    end
  end

endmodule

/* src/trap_csr_bank.sv */
// Trap and counter-control CSR registers
// WARL legalization of software writes, trap injection override
module trap_csr_bank (
  input  logic                  CLK,
  input  logic                  nRST,
  input  csr_pkg::csr_word_t    wdata,
  input  csr_pkg::csr_wsel_t    wsel,
  input  csr_pkg::trap_inject_t trap_inject,
  output csr_pkg::trap_state_t  trap_state
);

  csr_pkg::trap_state_t state_d;

  always_comb begin
    state_d = trap_state;

    // Software writes
    if (wsel.mstatus) begin
      state_d.mstatus      = '0;
      state_d.mstatus.mie  = wdata[3];
      state_d.mstatus.mpie = wdata[7];
      state_d.mstatus.mprv = wdata[17];
      state_d.mstatus.tw   = wdata[21];
      // Only U and M exist, S and reserved fall back to U
      state_d.mstatus.mpp  = (wdata[12:11] == 2'b11) ? csr_pkg::M_MODE : csr_pkg::U_MODE;
    end

    if (wsel.mtvec) begin
      state_d.mtvec.base = wdata[31:2];
      if (wdata[1:0] > 2'b01) begin
        state_d.mtvec.mode = csr_pkg::DIRECT;
      end else begin
        state_d.mtvec.mode = csr_pkg::mtvec_mode_t'(wdata[1:0]);
      end
    end

    if (wsel.mie) begin
      state_d.mie = csr_pkg::irq_bits_t'(wdata & csr_pkg::IRQ_MASK);
    end
    if (wsel.mip) begin
      state_d.mip = csr_pkg::irq_bits_t'(wdata & csr_pkg::IRQ_MASK);
    end
    if (wsel.mscratch) begin
      state_d.mscratch = wdata;
    end
    if (wsel.mepc) begin
      state_d.mepc = wdata;
    end
    if (wsel.mcause) begin
      state_d.mcause = wdata;
    end
    if (wsel.mtval) begin
      state_d.mtval = wdata;
    end
    if (wsel.mcounteren) begin
      state_d.mcounteren = csr_pkg::counter_en_t'(wdata);
    end
    if (wsel.mcountinhibit) begin
      state_d.mcountinhibit = csr_pkg::counter_en_t'(wdata);
    end

    // Trap entry and return take priority over software
    if (trap_inject.mstatus_en) begin
      state_d.mstatus = csr_pkg::mstatus_t'(trap_inject.mstatus & csr_pkg::MSTATUS_WMASK);
    end
    if (trap_inject.mepc_en) begin
      state_d.mepc = trap_inject.mepc;
    end
    if (trap_inject.mcause_en) begin
      state_d.mcause = trap_inject.mcause;
    end
    if (trap_inject.mtval_en) begin
      state_d.mtval = trap_inject.mtval;
    end
    if (trap_inject.mip_en) begin
      state_d.mip = csr_pkg::irq_bits_t'(trap_inject.mip & csr_pkg::IRQ_MASK);
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      trap_state <= '0;                  // mpp resets to U
      trap_state.mstatus.tw <= 1'b1;
      trap_state.mcounteren <= '1;       // All counters visible to U
    end else begin
      trap_state <= state_d;
    end
  end

endmodule
